//--- hdl/ctrlPkg.sv
package ctrlPkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths

	localparam int dataWidth = 16;
	localparam int opWidth = 4;
	localparam int regWidth = 4;
	localparam int opExWidth = 4;
	// Immediate fills the word below opcode and destination
	localparam int immWidth = dataWidth - opWidth - regWidth;
	localparam int psrWidth = 5;

	// Bit positions inside the status register
	localparam int flagC = 0;
	localparam int flagL = 1;
	localparam int flagF = 2;
	localparam int flagZ = 3;
	localparam int flagN = 4;

	typedef logic [regWidth-1:0] regIdx_t;
	typedef logic [immWidth-1:0] imm_t;
	typedef logic [psrWidth-1:0] psr_t;

	////////////////////////////////////////////////////////////////////////////
	// Instruction encodings

	typedef enum logic [opWidth-1:0] {
		OP_RTYPE = 4'd0,
		OP_ANDI = 4'd1,
		OP_ORI = 4'd2,
		OP_XORI = 4'd3,
		OP_OTYPE = 4'd4,
		OP_ADDI = 4'd5,
		OP_ADDUI = 4'd6,
		OP_STYPE = 4'd8,
		OP_SUBI = 4'd9,
		OP_CMPI = 4'd11,
		OP_BCOND = 4'd12,
		OP_MOVI = 4'd13,
		OP_LUI = 4'd15
	} opcode_t;

	typedef logic [opExWidth-1:0] opEx_t;

	// Register ALU forms, same codes as the matching immediate opcodes
	localparam opEx_t EX_AND = 4'd1;
	localparam opEx_t EX_OR = 4'd2;
	localparam opEx_t EX_XOR = 4'd3;
	localparam opEx_t EX_ADD = 4'd5;
	localparam opEx_t EX_ADDU = 4'd6;
	localparam opEx_t EX_SUB = 4'd9;
	localparam opEx_t EX_CMP = 4'd11;
	localparam opEx_t EX_MOV = 4'd13;

	// Memory, jump and set forms
	localparam opEx_t OX_LOAD = 4'd0;
	localparam opEx_t OX_STOR = 4'd4;
	localparam opEx_t OX_JAL = 4'd8;
	localparam opEx_t OX_JCOND = 4'd12;
	localparam opEx_t OX_SCOND = 4'd13;

	// Shift forms
	localparam opEx_t SX_LLSHI = 4'd0;
	localparam opEx_t SX_LRSHI = 4'd1;
	localparam opEx_t SX_ALSHUI = 4'd2;
	localparam opEx_t SX_ARSHUI = 4'd3;
	localparam opEx_t SX_LSH = 4'd4;
	localparam opEx_t SX_ASHU = 4'd6;

	typedef enum logic [3:0] {
		COND_EQ = 4'd0,
		COND_NE = 4'd1,
		COND_CS = 4'd2,
		COND_CC = 4'd3,
		COND_HI = 4'd4,
		COND_LS = 4'd5,
		COND_GT = 4'd6,
		COND_LE = 4'd7,
		COND_FS = 4'd8,
		COND_FC = 4'd9,
		COND_LO = 4'd10,
		COND_HS = 4'd11,
		COND_LT = 4'd12,
		COND_GE = 4'd13,
		COND_UC = 4'd14,
		COND_NV = 4'd15
	} cond_t;

	////////////////////////////////////////////////////////////////////////////
	// Datapath controls

	typedef enum logic [3:0] {
		ALU_NOP = 4'd0,
		ALU_ADD = 4'd1,
		ALU_ADDU = 4'd2,
		ALU_SUB = 4'd3,
		ALU_AND = 4'd4,
		ALU_OR = 4'd5,
		ALU_XOR = 4'd6,
		ALU_MOV = 4'd7,
		ALU_LUI = 4'd8,
		ALU_SLL = 4'd9,
		ALU_SRL = 4'd10,
		ALU_SLA = 4'd11,
		ALU_SRA = 4'd12
	} aluOp_t;

	typedef enum logic [1:0] {WB_LINK, WB_COND, WB_ALU, WB_MEM} wbSel_t;

	typedef enum logic [1:0] {CK_NONE, CK_BRANCH, CK_JUMP, CK_SET} condKind_t;

	// Register view and immediate view of the same word
	typedef struct packed {
		opcode_t op;
		regIdx_t dst;
		opEx_t opEx;
		regIdx_t src;
	} rForm_t;

	typedef struct packed {
		opcode_t op;
		regIdx_t dst;
		imm_t imm;
	} iForm_t;

	typedef union packed {
		rForm_t rForm;
		iForm_t iForm;
	} inst_u;

	typedef enum logic [1:0] {ST_FETCH, ST_DECODE, ST_LOAD} ctrlState_t;

endpackage

//--- hdl/instDecode.sv
`timescale 1ns/1ps

module instDecode
#(
	parameter ctrlPkg::regIdx_t linkReg = 4'd15
)
(
	input ctrlPkg::inst_u inst,
	input logic loadPhase,
	output ctrlPkg::aluOp_t aluOp,
	output ctrlPkg::wbSel_t wbSel,
	output logic immSel,
	output logic memSel,
	output logic writeEn,
	output logic psrSet,
	output logic pcAdvance,
	output logic isLoad,
	output ctrlPkg::regIdx_t rDst,
	output ctrlPkg::regIdx_t rSrc,
	output ctrlPkg::imm_t immVal,
	output ctrlPkg::cond_t condCode,
	output ctrlPkg::condKind_t condKind
);

	// ALU op for the arithmetic and logic forms
	// Immediate opcodes reuse the register extension codes, LUI only exists as immediate
	function automatic ctrlPkg::aluOp_t arithOp(input ctrlPkg::opEx_t code);
		case (code)
			ctrlPkg::EX_AND: arithOp = ctrlPkg::ALU_AND;
			ctrlPkg::EX_OR: arithOp = ctrlPkg::ALU_OR;
			ctrlPkg::EX_XOR: arithOp = ctrlPkg::ALU_XOR;
			ctrlPkg::EX_ADD: arithOp = ctrlPkg::ALU_ADD;
			ctrlPkg::EX_ADDU: arithOp = ctrlPkg::ALU_ADDU;
			ctrlPkg::EX_SUB: arithOp = ctrlPkg::ALU_SUB;
			ctrlPkg::EX_CMP: arithOp = ctrlPkg::ALU_SUB;
			ctrlPkg::EX_MOV: arithOp = ctrlPkg::ALU_MOV;
			ctrlPkg::OP_LUI: arithOp = ctrlPkg::ALU_LUI;
			default: arithOp = ctrlPkg::ALU_NOP;
		endcase
	endfunction

	always_comb
	begin
		aluOp = ctrlPkg::ALU_NOP;
		wbSel = ctrlPkg::WB_ALU;
		immSel = 1'b0;
		memSel = 1'b0;
		writeEn = 1'b0;
		psrSet = 1'b0;
		pcAdvance = 1'b0;
		isLoad = 1'b0;
		rDst = '0;
		rSrc = '0;
		immVal = '0;
		condCode = ctrlPkg::COND_NV;
		condKind = ctrlPkg::CK_NONE;

		case (inst.iForm.op)
			////////////////////////////////////////////////////////////////////////////
			// Immediate ALU forms
			ctrlPkg::OP_ANDI, ctrlPkg::OP_ORI, ctrlPkg::OP_XORI,
			ctrlPkg::OP_ADDI, ctrlPkg::OP_ADDUI, ctrlPkg::OP_SUBI,
			ctrlPkg::OP_CMPI, ctrlPkg::OP_MOVI, ctrlPkg::OP_LUI:
			begin
				rDst = inst.iForm.dst;
				immVal = inst.iForm.imm;
				aluOp = arithOp(inst.iForm.op);
				immSel = 1'b1;
				// Compare only updates flags
				writeEn = (inst.iForm.op != ctrlPkg::OP_CMPI);
				psrSet = 1'b1;
				pcAdvance = 1'b1;
			end

			////////////////////////////////////////////////////////////////////////////
			// Register ALU forms
			ctrlPkg::OP_RTYPE:
			begin
				case (inst.rForm.opEx)
					ctrlPkg::EX_AND, ctrlPkg::EX_OR, ctrlPkg::EX_XOR, ctrlPkg::EX_ADD,
					ctrlPkg::EX_ADDU, ctrlPkg::EX_SUB, ctrlPkg::EX_CMP, ctrlPkg::EX_MOV:
					begin
						rDst = inst.rForm.dst;
						rSrc = inst.rForm.src;
						aluOp = arithOp(inst.rForm.opEx);
						writeEn = (inst.rForm.opEx != ctrlPkg::EX_CMP);
						psrSet = 1'b1;
						pcAdvance = 1'b1;
					end
					default:
					begin
					end
				endcase
			end

			////////////////////////////////////////////////////////////////////////////
			// Shifts, flags untouched
			ctrlPkg::OP_STYPE:
			begin
				case (inst.rForm.opEx)
					ctrlPkg::SX_LSH, ctrlPkg::SX_ASHU:
					begin
						rDst = inst.rForm.dst;
						rSrc = inst.rForm.src;
						aluOp = (inst.rForm.opEx == ctrlPkg::SX_LSH) ?
							ctrlPkg::ALU_SLL : ctrlPkg::ALU_SLA;
						writeEn = 1'b1;
						pcAdvance = 1'b1;
					end
					ctrlPkg::SX_LLSHI, ctrlPkg::SX_LRSHI, ctrlPkg::SX_ALSHUI,
					ctrlPkg::SX_ARSHUI:
					begin
						rDst = inst.rForm.dst;
						// Shift amount is the low nibble, zero extended
						immVal = {{(ctrlPkg::immWidth - ctrlPkg::regWidth){1'b0}},
							inst.rForm.src};
						case (inst.rForm.opEx)
							ctrlPkg::SX_LLSHI: aluOp = ctrlPkg::ALU_SLL;
							ctrlPkg::SX_LRSHI: aluOp = ctrlPkg::ALU_SRL;
							ctrlPkg::SX_ALSHUI: aluOp = ctrlPkg::ALU_SLA;
							default: aluOp = ctrlPkg::ALU_SRA;
						endcase
						writeEn = 1'b1;
						pcAdvance = 1'b1;
					end
					default:
					begin
					end
				endcase
			end

			////////////////////////////////////////////////////////////////////////////
			// Memory, jumps and set-on-condition
			ctrlPkg::OP_OTYPE:
			begin
				case (inst.rForm.opEx)
					ctrlPkg::OX_LOAD:
					begin
						rSrc = inst.rForm.src;
						memSel = 1'b1;
						if (loadPhase)
						begin
							// Second cycle writes the memory word back
							rDst = inst.rForm.dst;
							writeEn = 1'b1;
							wbSel = ctrlPkg::WB_MEM;
							pcAdvance = 1'b1;
						end
						else
						begin
							isLoad = 1'b1;
						end
					end
					ctrlPkg::OX_STOR:
					begin
						rDst = inst.rForm.dst;
						rSrc = inst.rForm.src;
						memSel = 1'b1;
						pcAdvance = 1'b1;
					end
					ctrlPkg::OX_SCOND:
					begin
						rDst = inst.rForm.dst;
						wbSel = ctrlPkg::WB_COND;
						writeEn = 1'b1;
						pcAdvance = 1'b1;
						condKind = ctrlPkg::CK_SET;
						condCode = ctrlPkg::cond_t'(inst.rForm.src);
					end
					ctrlPkg::OX_JCOND:
					begin
						rSrc = inst.rForm.src;
						pcAdvance = 1'b1;
						// Condition sits in the dst nibble here
						condKind = ctrlPkg::CK_JUMP;
						condCode = ctrlPkg::cond_t'(inst.rForm.dst);
					end
					ctrlPkg::OX_JAL:
					begin
						rDst = linkReg;
						rSrc = inst.rForm.src;
						writeEn = 1'b1;
						wbSel = ctrlPkg::WB_LINK;
						pcAdvance = 1'b1;
						condKind = ctrlPkg::CK_JUMP;
						condCode = ctrlPkg::COND_UC;
					end
					default:
					begin
					end
				endcase
			end

			ctrlPkg::OP_BCOND:
			begin
				immVal = inst.iForm.imm;
				immSel = 1'b1;
				pcAdvance = 1'b1;
				condKind = ctrlPkg::CK_BRANCH;
				condCode = ctrlPkg::cond_t'(inst.rForm.src);
			end

			default:
			begin
			end
		endcase
	end

endmodule

//--- hdl/condEval.sv
`timescale 1ns/1ps

module condEval
(
	input logic clk,
	input logic rst,
	input ctrlPkg::psr_t psrIn,
	input logic psrLoad,
	input ctrlPkg::cond_t condCode,
	input ctrlPkg::condKind_t condKind,
	output logic condTrue
);

	ctrlPkg::psr_t psr;
	logic hit;

	// Status register, loaded by flag-setting instructions only
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			psr <= '0;
		end
		else if (psrLoad)
		begin
			psr <= psrIn;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Condition table

	always_comb
	begin
		case (condCode)
			ctrlPkg::COND_EQ: hit = psr[ctrlPkg::flagZ];
			ctrlPkg::COND_NE: hit = !psr[ctrlPkg::flagZ];
			ctrlPkg::COND_CS: hit = psr[ctrlPkg::flagC];
			ctrlPkg::COND_CC: hit = !psr[ctrlPkg::flagC];
			ctrlPkg::COND_HI: hit = psr[ctrlPkg::flagL];
			ctrlPkg::COND_LS: hit = !psr[ctrlPkg::flagL];
			ctrlPkg::COND_GT: hit = psr[ctrlPkg::flagN];
			ctrlPkg::COND_LE: hit = !psr[ctrlPkg::flagN];
			ctrlPkg::COND_FS: hit = psr[ctrlPkg::flagF];
			ctrlPkg::COND_FC: hit = !psr[ctrlPkg::flagF];
			ctrlPkg::COND_HS: hit = psr[ctrlPkg::flagZ] | psr[ctrlPkg::flagL];
			ctrlPkg::COND_LO: hit = !(psr[ctrlPkg::flagZ] | psr[ctrlPkg::flagL]);
			ctrlPkg::COND_GE: hit = psr[ctrlPkg::flagZ] | psr[ctrlPkg::flagN];
			ctrlPkg::COND_LT: hit = !(psr[ctrlPkg::flagZ] | psr[ctrlPkg::flagN]);
			// Unconditional only counts for jumps
			ctrlPkg::COND_UC: hit = (condKind == ctrlPkg::CK_JUMP);
			default: hit = 1'b0;
		endcase
	end

	assign condTrue = hit && (condKind != ctrlPkg::CK_NONE);

endmodule

//--- hdl/ctrlSequencer.sv
`timescale 1ns/1ps

module ctrlSequencer
(
	input logic clk,
	input logic rst,
	// Control set from the decoder
	input ctrlPkg::aluOp_t decAluOp,
	input logic decImmSel,
	input logic decMemSel,
	input logic decWriteEn,
	input logic decPsrSet,
	input logic decPcAdvance,
	input ctrlPkg::wbSel_t decWbSel,
	input ctrlPkg::regIdx_t decRDst,
	input ctrlPkg::regIdx_t decRSrc,
	input ctrlPkg::imm_t decImmVal,
	input logic decIsLoad,
	input ctrlPkg::condKind_t condKind,
	input logic condTrue,
	output logic branch,
	output logic jump,
	output logic romMux,
	output logic memcMux,
	output logic immMux,
	output logic pcEn,
	output logic write,
	output logic condRslt,
	output logic psrLoad,
	output logic loadPhase,
	output ctrlPkg::wbSel_t wbMux,
	output ctrlPkg::regIdx_t rDst,
	output ctrlPkg::regIdx_t rSrc,
	output ctrlPkg::imm_t immVal,
	output ctrlPkg::aluOp_t aluOp
);

	ctrlPkg::ctrlState_t state;
	ctrlPkg::ctrlState_t nextState;
	logic active;

	////////////////////////////////////////////////////////////////////////////
	// State machine

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= ctrlPkg::ST_FETCH;
		end
		else
		begin
			state <= nextState;
		end
	end

	always_comb
	begin
		case (state)
			ctrlPkg::ST_FETCH: nextState = ctrlPkg::ST_DECODE;
			// Only a load needs the extra cycle
			ctrlPkg::ST_DECODE: nextState = decIsLoad ? ctrlPkg::ST_LOAD : ctrlPkg::ST_FETCH;
			default: nextState = ctrlPkg::ST_FETCH;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Output gating

	assign active = (state != ctrlPkg::ST_FETCH);
	assign loadPhase = (state == ctrlPkg::ST_LOAD);
	assign psrLoad = decPsrSet && (state == ctrlPkg::ST_DECODE);
	// Instruction ROM select is never switched
	assign romMux = 1'b0;

	always_comb
	begin
		branch = 1'b0;
		jump = 1'b0;
		condRslt = 1'b0;
		memcMux = 1'b0;
		immMux = 1'b0;
		pcEn = 1'b0;
		write = 1'b0;
		wbMux = ctrlPkg::WB_ALU;
		rDst = '0;
		rSrc = '0;
		immVal = '0;
		aluOp = ctrlPkg::ALU_NOP;
		if (active)
		begin
			// Route condition result by instruction kind
			branch = condTrue && (condKind == ctrlPkg::CK_BRANCH);
			jump = condTrue && (condKind == ctrlPkg::CK_JUMP);
			condRslt = condTrue && (condKind == ctrlPkg::CK_SET);
			memcMux = decMemSel;
			immMux = decImmSel;
			pcEn = decPcAdvance;
			write = decWriteEn;
			wbMux = decWbSel;
			rDst = decRDst;
			rSrc = decRSrc;
			immVal = decImmVal;
			aluOp = decAluOp;
		end
	end

endmodule

//--- hdl/controller.sv
`timescale 1ns/1ps

module controller
#(
	parameter ctrlPkg::regIdx_t linkReg = 4'd15
)
(
	input logic clk,
	input logic rst,
	input ctrlPkg::psr_t psrIn,
	input ctrlPkg::inst_u inst,
	output logic branch,
	output logic jump,
	output logic romMux,
	output logic memcMux,
	output logic immMux,
	output logic pcEn,
	output logic write,
	output logic condRslt,
	output ctrlPkg::wbSel_t wbMux,
	output ctrlPkg::regIdx_t rDst,
	output ctrlPkg::regIdx_t rSrc,
	output ctrlPkg::imm_t immVal,
	output ctrlPkg::aluOp_t aluOp
);

	// Decoder results
	ctrlPkg::aluOp_t decAluOp;
	ctrlPkg::wbSel_t decWbSel;
	logic decImmSel;
	logic decMemSel;
	logic decWriteEn;
	logic decPsrSet;
	logic decPcAdvance;
	logic decIsLoad;
	ctrlPkg::regIdx_t decRDst;
	ctrlPkg::regIdx_t decRSrc;
	ctrlPkg::imm_t decImmVal;
	ctrlPkg::cond_t condCode;
	ctrlPkg::condKind_t condKind;

	// Sequencer feedback
	logic condTrue;
	logic psrLoad;
	logic loadPhase;

	instDecode #(
		.linkReg(linkReg)
	) u_instDecode (
		.inst(inst),
		.loadPhase(loadPhase),
		.aluOp(decAluOp),
		.wbSel(decWbSel),
		.immSel(decImmSel),
		.memSel(decMemSel),
		.writeEn(decWriteEn),
		.psrSet(decPsrSet),
		.pcAdvance(decPcAdvance),
		.isLoad(decIsLoad),
		.rDst(decRDst),
		.rSrc(decRSrc),
		.immVal(decImmVal),
		.condCode(condCode),
		.condKind(condKind)
	);

	condEval u_condEval (
		.clk(clk),
		.rst(rst),
		.psrIn(psrIn),
		.psrLoad(psrLoad),
		.condCode(condCode),
		.condKind(condKind),
		.condTrue(condTrue)
	);

	ctrlSequencer u_ctrlSequencer (
		.clk(clk),
		.rst(rst),
		.decAluOp(decAluOp),
		.decImmSel(decImmSel),
		.decMemSel(decMemSel),
		.decWriteEn(decWriteEn),
		.decPsrSet(decPsrSet),
		.decPcAdvance(decPcAdvance),
		.decWbSel(decWbSel),
		.decRDst(decRDst),
		.decRSrc(decRSrc),
		.decImmVal(decImmVal),
		.decIsLoad(decIsLoad),
		.condKind(condKind),
		.condTrue(condTrue),
		.branch(branch),
		.jump(jump),
		.romMux(romMux),
		.memcMux(memcMux),
		.immMux(immMux),
		.pcEn(pcEn),
		.write(write),
		.condRslt(condRslt),
		.psrLoad(psrLoad),
		.loadPhase(loadPhase),
		.wbMux(wbMux),
		.rDst(rDst),
		.rSrc(rSrc),
		.immVal(immVal),
		.aluOp(aluOp)
	);

endmodule

//--- dv/controllerTb.sv
`timescale 1ns/1ps

module controllerTb;

	localparam int numInsts = 400;
	localparam int clkPeriod = 20;
	localparam ctrlPkg::regIdx_t linkReg = 4'd15;
	// Three cycles at most per instruction, plus reset and slack
	localparam int timeLimit = numInsts * 3 * clkPeriod + 20 * clkPeriod;

	// Nibble tables of valid codes, entry 0 in the low nibble
	localparam logic [63:0] immOps = 64'h0000_000F_DB96_5321;
	localparam logic [63:0] regExs = 64'h0000_0000_DB96_5321;
	localparam logic [63:0] shiftExs = 64'h0000_0000_0064_3210;
	localparam logic [63:0] oExs = 64'h0000_0000_000D_C840;
	localparam logic [63:0] twoLevelOps = 64'h0000_0000_0000_0840;
	localparam logic [63:0] unknownOps = 64'h0000_0000_0000_0EA7;

	logic clk;
	logic rst;
	ctrlPkg::psr_t psrIn;
	ctrlPkg::inst_u inst;
	logic branch;
	logic jump;
	logic romMux;
	logic memcMux;
	logic immMux;
	logic pcEn;
	logic write;
	logic condRslt;
	ctrlPkg::wbSel_t wbMux;
	ctrlPkg::regIdx_t rDst;
	ctrlPkg::regIdx_t rSrc;
	ctrlPkg::imm_t immVal;
	ctrlPkg::aluOp_t aluOp;

	// Reference model state and expected outputs
	ctrlPkg::ctrlState_t modelState;
	ctrlPkg::psr_t modelPsr;
	logic expBranch;
	logic expJump;
	logic expMemcMux;
	logic expImmMux;
	logic expPcEn;
	logic expWrite;
	logic expCondRslt;
	ctrlPkg::wbSel_t expWbMux;
	ctrlPkg::regIdx_t expRDst;
	ctrlPkg::regIdx_t expRSrc;
	ctrlPkg::imm_t expImmVal;
	ctrlPkg::aluOp_t expAluOp;

	logic [31:0] rngState;
	logic [31:0] draw;
	logic [15:0] curInst;
	int errors;
	int checks;
	int n;

	controller #(
		.linkReg(linkReg)
	) u_controller (
		.clk(clk),
		.rst(rst),
		.psrIn(psrIn),
		.inst(inst),
		.branch(branch),
		.jump(jump),
		.romMux(romMux),
		.memcMux(memcMux),
		.immMux(immMux),
		.pcEn(pcEn),
		.write(write),
		.condRslt(condRslt),
		.wbMux(wbMux),
		.rDst(rDst),
		.rSrc(rSrc),
		.immVal(immVal),
		.aluOp(aluOp)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(clkPeriod / 2) clk = ~clk;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Random stimulus

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic nextRandom(output logic [31:0] value);
		rngState = xorshift32(rngState);
		value = rngState;
	endtask

	function automatic logic [3:0] pickNibble(input logic [63:0] codes, input int count,
		input logic [3:0] key);
		int pos;
		pos = 4 * (int'(key) % count);
		return codes[pos +: 4];
	endfunction

	// Class first, so that every instruction kind shows up often
	task automatic makeInst(output logic [15:0] word);
		logic [31:0] sel;
		logic [31:0] f;
		nextRandom(sel);
		nextRandom(f);
		case (sel[2:0])
			3'd0, 3'd1: word = {pickNibble(immOps, 9, f[19:16]), f[11:0]};
			3'd2: word = {4'd0, f[11:8], pickNibble(regExs, 8, f[19:16]), f[3:0]};
			3'd3: word = {4'd8, f[11:8], pickNibble(shiftExs, 6, f[19:16]), f[3:0]};
			3'd4: word = {4'd4, f[11:8], pickNibble(oExs, 5, f[19:16]), f[3:0]};
			3'd5: word = {4'd12, f[11:0]};
			// Any extension, valid or not
			3'd6: word = {pickNibble(twoLevelOps, 3, f[19:16]), f[11:0]};
			default: word = {pickNibble(unknownOps, 3, f[19:16]), f[11:0]};
		endcase
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model

	function automatic logic isImmAlu(input logic [3:0] op);
		return op inside {4'd1, 4'd2, 4'd3, 4'd5, 4'd6, 4'd9, 4'd11, 4'd13, 4'd15};
	endfunction

	function automatic logic isRegAlu(input logic [3:0] ex);
		return ex inside {4'd1, 4'd2, 4'd3, 4'd5, 4'd6, 4'd9, 4'd11, 4'd13};
	endfunction

	function automatic ctrlPkg::aluOp_t modelAluOp(input logic [3:0] code);
		ctrlPkg::aluOp_t r;
		case (code)
			4'd1: r = ctrlPkg::ALU_AND;
			4'd2: r = ctrlPkg::ALU_OR;
			4'd3: r = ctrlPkg::ALU_XOR;
			4'd5: r = ctrlPkg::ALU_ADD;
			4'd6: r = ctrlPkg::ALU_ADDU;
			4'd9, 4'd11: r = ctrlPkg::ALU_SUB;
			4'd13: r = ctrlPkg::ALU_MOV;
			4'd15: r = ctrlPkg::ALU_LUI;
			default: r = ctrlPkg::ALU_NOP;
		endcase
		return r;
	endfunction

	function automatic logic condHolds(input logic [3:0] code,
		input ctrlPkg::condKind_t kind, input ctrlPkg::psr_t p);
		logic fC;
		logic fL;
		logic fF;
		logic fZ;
		logic fN;
		logic r;
		fC = p[ctrlPkg::flagC];
		fL = p[ctrlPkg::flagL];
		fF = p[ctrlPkg::flagF];
		fZ = p[ctrlPkg::flagZ];
		fN = p[ctrlPkg::flagN];
		case (code)
			4'd0: r = fZ;
			4'd1: r = !fZ;
			4'd2: r = fC;
			4'd3: r = !fC;
			4'd4: r = fL;
			4'd5: r = !fL;
			4'd6: r = fN;
			4'd7: r = !fN;
			4'd8: r = fF;
			4'd9: r = !fF;
			4'd10: r = !(fZ || fL);
			4'd11: r = fZ || fL;
			4'd12: r = !(fZ || fN);
			4'd13: r = fZ || fN;
			4'd14: r = (kind == ctrlPkg::CK_JUMP);
			default: r = 1'b0;
		endcase
		return r && (kind != ctrlPkg::CK_NONE);
	endfunction

	task automatic predict();
		logic [15:0] word;
		logic [3:0] op;
		logic [3:0] dst;
		logic [3:0] ex;
		logic [3:0] src;
		logic [3:0] code;
		ctrlPkg::condKind_t kind;
		logic hit;
		word = inst;
		op = word[15:12];
		dst = word[11:8];
		ex = word[7:4];
		src = word[3:0];
		code = 4'd15;
		kind = ctrlPkg::CK_NONE;
		expMemcMux = 1'b0;
		expImmMux = 1'b0;
		expPcEn = 1'b0;
		expWrite = 1'b0;
		expWbMux = ctrlPkg::WB_ALU;
		expRDst = '0;
		expRSrc = '0;
		expImmVal = '0;
		expAluOp = ctrlPkg::ALU_NOP;
		if (modelState != ctrlPkg::ST_FETCH)
		begin
			if (isImmAlu(op))
			begin
				expRDst = dst;
				expImmVal = word[7:0];
				expImmMux = 1'b1;
				expAluOp = modelAluOp(op);
				expWrite = (op != 4'd11);
				expPcEn = 1'b1;
			end
			else if (op == 4'd0 && isRegAlu(ex))
			begin
				expRDst = dst;
				expRSrc = src;
				expAluOp = modelAluOp(ex);
				expWrite = (ex != 4'd11);
				expPcEn = 1'b1;
			end
			else if (op == 4'd8 && ex inside {4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd6})
			begin
				expRDst = dst;
				expWrite = 1'b1;
				expPcEn = 1'b1;
				if (ex == 4'd4 || ex == 4'd6)
				begin
					expRSrc = src;
				end
				else
				begin
					expImmVal = {4'd0, src};
				end
				case (ex)
					4'd0, 4'd4: expAluOp = ctrlPkg::ALU_SLL;
					4'd1: expAluOp = ctrlPkg::ALU_SRL;
					4'd3: expAluOp = ctrlPkg::ALU_SRA;
					default: expAluOp = ctrlPkg::ALU_SLA;
				endcase
			end
			else if (op == 4'd4 && ex == 4'd0)
			begin
				// Address first, then the write back of the memory word
				expRSrc = src;
				expMemcMux = 1'b1;
				if (modelState == ctrlPkg::ST_LOAD)
				begin
					expRDst = dst;
					expWrite = 1'b1;
					expWbMux = ctrlPkg::WB_MEM;
					expPcEn = 1'b1;
				end
			end
			else if (op == 4'd4 && ex == 4'd4)
			begin
				expRDst = dst;
				expRSrc = src;
				expMemcMux = 1'b1;
				expPcEn = 1'b1;
			end
			else if (op == 4'd4 && ex == 4'd8)
			begin
				expRDst = linkReg;
				expRSrc = src;
				expWrite = 1'b1;
				expWbMux = ctrlPkg::WB_LINK;
				expPcEn = 1'b1;
				kind = ctrlPkg::CK_JUMP;
				code = 4'd14;
			end
			else if (op == 4'd4 && ex == 4'd12)
			begin
				expRSrc = src;
				expPcEn = 1'b1;
				kind = ctrlPkg::CK_JUMP;
				code = dst;
			end
			else if (op == 4'd4 && ex == 4'd13)
			begin
				expRDst = dst;
				expWbMux = ctrlPkg::WB_COND;
				expWrite = 1'b1;
				expPcEn = 1'b1;
				kind = ctrlPkg::CK_SET;
				code = src;
			end
			else if (op == 4'd12)
			begin
				expImmVal = word[7:0];
				expImmMux = 1'b1;
				expPcEn = 1'b1;
				kind = ctrlPkg::CK_BRANCH;
				code = src;
			end
		end
		hit = condHolds(code, kind, modelPsr);
		expBranch = hit && (kind == ctrlPkg::CK_BRANCH);
		expJump = hit && (kind == ctrlPkg::CK_JUMP);
		expCondRslt = hit && (kind == ctrlPkg::CK_SET);
	endtask

	// Model update at the rising edge
	task automatic advanceModel();
		logic [15:0] word;
		word = inst;
		case (modelState)
			ctrlPkg::ST_FETCH: modelState = ctrlPkg::ST_DECODE;
			ctrlPkg::ST_DECODE:
			begin
				if (isImmAlu(word[15:12]) || (word[15:12] == 4'd0 && isRegAlu(word[7:4])))
				begin
					modelPsr = psrIn;
				end
				if (word[15:12] == 4'd4 && word[7:4] == 4'd0)
				begin
					modelState = ctrlPkg::ST_LOAD;
				end
				else
				begin
					modelState = ctrlPkg::ST_FETCH;
				end
			end
			default: modelState = ctrlPkg::ST_FETCH;
		endcase
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic checkBit(input string name, input logic got, input logic exp);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("FAILED %s: got %h expected %h, inst %h at %0t", name, got, exp,
				curInst, $time);
		end
	endtask

	task automatic checkWbSel(input string name, input ctrlPkg::wbSel_t got,
		input ctrlPkg::wbSel_t exp);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("FAILED %s: got %h expected %h, inst %h at %0t", name, got, exp,
				curInst, $time);
		end
	endtask

	task automatic checkReg(input string name, input ctrlPkg::regIdx_t got,
		input ctrlPkg::regIdx_t exp);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("FAILED %s: got %h expected %h, inst %h at %0t", name, got, exp,
				curInst, $time);
		end
	endtask

	task automatic checkImm(input string name, input ctrlPkg::imm_t got,
		input ctrlPkg::imm_t exp);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("FAILED %s: got %h expected %h, inst %h at %0t", name, got, exp,
				curInst, $time);
		end
	endtask

	task automatic checkAluOp(input string name, input ctrlPkg::aluOp_t got,
		input ctrlPkg::aluOp_t exp);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("FAILED %s: got %h expected %h, inst %h at %0t", name, got, exp,
				curInst, $time);
		end
	endtask

	task automatic compareAll();
		checkBit("branch", branch, expBranch);
		checkBit("jump", jump, expJump);
		checkBit("romMux", romMux, 1'b0);
		checkBit("memcMux", memcMux, expMemcMux);
		checkBit("immMux", immMux, expImmMux);
		checkBit("pcEn", pcEn, expPcEn);
		checkBit("write", write, expWrite);
		checkBit("condRslt", condRslt, expCondRslt);
		checkWbSel("wbMux", wbMux, expWbMux);
		checkReg("rDst", rDst, expRDst);
		checkReg("rSrc", rSrc, expRSrc);
		checkImm("immVal", immVal, expImmVal);
		checkAluOp("aluOp", aluOp, expAluOp);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial
	begin
		errors = 0;
		checks = 0;
		rngState = 32'h766a_d585;
		modelState = ctrlPkg::ST_FETCH;
		modelPsr = '0;
		rst = 1'b0;
		psrIn = '0;
		makeInst(curInst);
		inst = curInst;
		// Outputs stay quiet while reset is held
		repeat (3)
		begin
			@(negedge clk);
			predict();
			compareAll();
			@(posedge clk);
		end
		#2;
		rst = 1'b1;
		for (n = 0; n < numInsts; n++)
		begin
			makeInst(curInst);
			inst = curInst;
			do
			begin
				nextRandom(draw);
				psrIn = draw[4:0];
				@(negedge clk);
				predict();
				compareAll();
				@(posedge clk);
				advanceModel();
				#2;
			end
			while (modelState != ctrlPkg::ST_FETCH);
		end
		@(negedge clk);
		predict();
		compareAll();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
		begin
			$display("Test OK");
		end
		else
		begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial
	begin
		#(timeLimit);
		$display("Timeout: the run did not finish within %0d ns", timeLimit);
		$display("Test FAILED");
		$finish;
	end

endmodule

//--- compile.f
hdl/ctrlPkg.sv
hdl/instDecode.sv
hdl/condEval.sv
hdl/ctrlSequencer.sv
hdl/controller.sv
dv/controllerTb.sv

//--- run.sh
#!/bin/sh
# Build and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timescale 1ns/1ps -f compile.f --top-module controllerTb \
	-o controllerTbSim
simOut=$(./obj_dir/controllerTbSim)
echo "$simOut"
if echo "$simOut" | grep -qx "Test OK"; then
	exit 0
fi
exit 1
